// File: rtl/apb_bus_pkg.sv
`default_nettype none

package apb_bus_pkg;

    // System bus side
    localparam int ADDR_BITS     = 32;
    localparam int BUS_DATA_BITS = 64;
    localparam int BUS_STRB_BITS = BUS_DATA_BITS / 8;

    // APB side carries one 32-bit lane per transfer
    localparam int APB_DATA_BITS = 32;
    localparam int APB_STRB_BITS = APB_DATA_BITS / 8;

    // Each slave owns a 4 KiB region indexed by addr[31:12]
    localparam int SLV_REGION_BITS = 12;

    // Single request from the system bus
    typedef struct packed {
        logic [ADDR_BITS-1:0]     addr;
        logic [7:0]               size;     // 4 or 8 bytes
        logic                     write;
        logic [BUS_DATA_BITS-1:0] wdata;
        logic [BUS_STRB_BITS-1:0] wstrb;
        logic                     last;     // Low marks a burst beat
    } bus_req_t;

    typedef struct packed {
        logic [BUS_DATA_BITS-1:0] rdata;
        logic                     err;
    } bus_resp_t;

    // Master to slave
    typedef struct packed {
        logic [ADDR_BITS-1:0]     paddr;
        logic                     pwrite;
        logic [APB_DATA_BITS-1:0] pwdata;
        logic [APB_STRB_BITS-1:0] pstrb;
        logic                     psel;
        logic                     penable;
    } apb_in_t;

    // Slave to master
    typedef struct packed {
        logic [APB_DATA_BITS-1:0] prdata;
        logic                     pready;
        logic                     pslverr;
    } apb_out_t;

    // Answer of the unmapped default slave
    localparam apb_out_t APB_OUT_UNMAPPED = '{
        prdata:  '1,
        pready:  1'b1,
        pslverr: 1'b1
    };

endpackage

`default_nettype wire

// File: rtl/bus_req_queue.sv
`default_nettype none

module bus_req_queue (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire apb_bus_pkg::bus_req_t i_req,
    input  wire logic                  i_req_valid,
    output logic                       o_req_ready,
    output apb_bus_pkg::bus_req_t      o_req,
    output logic                       o_req_valid,
    input  wire logic                  i_req_ready
);
    import apb_bus_pkg::*;

    bus_req_t   mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign o_req_ready = (count != 2'd2);   // Low only when both slots hold a request
    assign o_req_valid = (count != 2'd0);
    assign o_req       = mem[rd_ptr];

    assign push = i_req_valid && o_req_ready;
    assign pop  = o_req_valid && i_req_ready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
            case ({push, pop})
                2'b10:   count <= count + 2'd1;
                2'b01:   count <= count - 2'd1;
                default: count <= count;        // Idle, or push and pop together
            endcase
        end
    end

    // Storage slots
    always_ff @(posedge i_clk) begin
        if (push) begin
            mem[wr_ptr] <= i_req;
        end
    end

    // A push lands on a free slot and never on the held head
    a_no_push_full: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        push |-> (((count == 2'd0) && (wr_ptr == rd_ptr))
                  || ((count == 2'd1) && (wr_ptr != rd_ptr)))
    ) else $error("Request pushed into a full queue");

    // Head must hold still while the bridge stalls
    a_out_stable: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_req_valid && !i_req_ready) |=> (o_req_valid && $stable(o_req))
    ) else $error("Queue output changed while stalled");

endmodule

`default_nettype wire

// File: rtl/apb_bridge.sv
`default_nettype none

module apb_bridge #(
    parameter int P_NSLV = 4
) (
    input  wire logic                   i_clk,
    input  wire logic                   i_nrst,
    input  wire apb_bus_pkg::bus_req_t  i_req,
    input  wire logic                   i_req_valid,
    output logic                        o_req_ready,
    output apb_bus_pkg::apb_in_t        o_apbi,
    output logic [P_NSLV-1:0]           o_psel,
    output logic [$clog2(P_NSLV+1)-1:0] o_sel_idx,
    input  wire apb_bus_pkg::apb_out_t  i_apbo,
    output apb_bus_pkg::bus_resp_t      o_resp,
    output logic                        o_resp_valid,
    input  wire logic                   i_resp_ready
);
    import apb_bus_pkg::*;

    localparam int IDX_W = $clog2(P_NSLV + 1);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_SETUP,
        ST_ACCESS,
        ST_DONE
    } state_t;

    state_t                               state;
    logic                                 psel_r;
    logic                                 penable_r;
    logic                                 pwrite_r;
    logic                                 beat_two;     // Second lane still to go
    logic                                 err_r;
    logic [IDX_W-1:0]                     sel_idx_r;
    logic [IDX_W-1:0]                     dec_idx;
    logic [ADDR_BITS-1:0]                 paddr_r;
    logic [APB_DATA_BITS-1:0]             pwdata_r;
    logic [APB_DATA_BITS-1:0]             wdata_hi;
    logic [APB_STRB_BITS-1:0]             pstrb_r;
    logic [APB_STRB_BITS-1:0]             wstrb_hi;
    logic [BUS_DATA_BITS-1:0]             rdata_r;
    logic [ADDR_BITS-SLV_REGION_BITS-1:0] region;
    logic                                 req_fire;
    logic                                 xfer_done;

    // Region number past the map selects the default slave
    assign region  = i_req.addr[ADDR_BITS-1:SLV_REGION_BITS];
    assign dec_idx = (region < P_NSLV) ? IDX_W'(region) : IDX_W'(P_NSLV);

    assign o_req_ready  = (state == ST_IDLE);
    assign o_resp_valid = (state == ST_DONE);
    assign req_fire     = i_req_valid && o_req_ready;
    assign xfer_done    = (state == ST_ACCESS) && i_apbo.pready;

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state     <= ST_IDLE;
            psel_r    <= 1'b0;
            penable_r <= 1'b0;
            pwrite_r  <= 1'b0;
            beat_two  <= 1'b0;
            err_r     <= 1'b0;
            sel_idx_r <= IDX_W'(P_NSLV);
        end else begin
            case (state)
                ST_IDLE: begin
                    if (req_fire) begin
                        sel_idx_r <= dec_idx;
                        pwrite_r  <= i_req.write;
                        beat_two  <= (i_req.size > 8'd4);
                        if (!i_req.last) begin
                            // Bursts are refused without touching APB
                            err_r <= 1'b1;
                            state <= ST_DONE;
                        end else begin
                            err_r  <= 1'b0;
                            psel_r <= 1'b1;
                            state  <= ST_SETUP;
                        end
                    end
                end
                ST_SETUP: begin
                    penable_r <= 1'b1;
                    state     <= ST_ACCESS;
                end
                ST_ACCESS: begin
                    if (i_apbo.pready) begin
                        penable_r <= 1'b0;
                        err_r     <= err_r | i_apbo.pslverr;
                        if (beat_two) begin
                            beat_two <= 1'b0;
                            state    <= ST_SETUP;   // psel stays high
                        end else begin
                            psel_r   <= 1'b0;
                            pwrite_r <= 1'b0;
                            state    <= ST_DONE;
                        end
                    end
                end
                ST_DONE: begin
                    if (i_resp_ready) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address, lane data and collected read data
    always_ff @(posedge i_clk) begin
        if (req_fire) begin
            paddr_r  <= {i_req.addr[ADDR_BITS-1:2], 2'b00};
            wdata_hi <= i_req.wdata[BUS_DATA_BITS-1:APB_DATA_BITS];
            wstrb_hi <= i_req.wstrb[BUS_STRB_BITS-1:APB_STRB_BITS];
            rdata_r  <= i_req.last ? '0 : '1;
            if (i_req.addr[2]) begin
                pwdata_r <= i_req.wdata[BUS_DATA_BITS-1:APB_DATA_BITS];
                pstrb_r  <= i_req.wstrb[BUS_STRB_BITS-1:APB_STRB_BITS];
            end else begin
                pwdata_r <= i_req.wdata[APB_DATA_BITS-1:0];
                pstrb_r  <= i_req.wstrb[APB_STRB_BITS-1:0];
            end
        end else if (xfer_done) begin
            if (paddr_r[2]) begin
                rdata_r[BUS_DATA_BITS-1:APB_DATA_BITS] <= i_apbo.prdata;
            end else begin
                rdata_r[APB_DATA_BITS-1:0] <= i_apbo.prdata;
            end
            if (beat_two) begin
                paddr_r  <= paddr_r + ADDR_BITS'(4);
                pwdata_r <= wdata_hi;
                pstrb_r  <= wstrb_hi;
            end
        end
    end

    // Only the addressed slave sees psel
    always_comb begin
        o_psel = '0;
        for (int i = 0; i < P_NSLV; i++) begin
            if (sel_idx_r == IDX_W'(i)) begin
                o_psel[i] = psel_r;
            end
        end
    end

    assign o_apbi = '{
        paddr:   paddr_r,
        pwrite:  pwrite_r,
        pwdata:  pwdata_r,
        pstrb:   pstrb_r,
        psel:    psel_r,
        penable: penable_r
    };
    assign o_sel_idx = sel_idx_r;
    assign o_resp    = '{rdata: rdata_r, err: err_r};

    a_penable_psel: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        o_apbi.penable |-> o_apbi.psel
    ) else $error("penable high without psel");

    a_paddr_stable: assert property (
        @(posedge i_clk) disable iff (!i_nrst)
        (o_apbi.penable && !i_apbo.pready) |=> $stable(o_apbi.paddr)
    ) else $error("paddr changed during an access phase");

endmodule

`default_nettype wire

// File: rtl/apb_reg_slave.sv
`default_nettype none

module apb_reg_slave #(
    parameter int P_NREGS = 16,
    parameter int P_WAIT  = 1
) (
    input  wire logic                  i_clk,
    input  wire logic                  i_nrst,
    input  wire apb_bus_pkg::apb_in_t  i_apbi,
    input  wire logic                  i_psel,
    output apb_bus_pkg::apb_out_t      o_apbo
);
    import apb_bus_pkg::*;

    localparam int OFF_W  = SLV_REGION_BITS - 2;
    localparam int WAIT_W = (P_WAIT > 0) ? $clog2(P_WAIT + 1) : 1;

    logic [APB_DATA_BITS-1:0] regs [P_NREGS];
    logic [WAIT_W-1:0]        wait_cnt;
    logic [OFF_W-1:0]         word_off;
    logic [APB_DATA_BITS-1:0] rd_word;
    logic                     access;
    logic                     ready;
    logic                     bad_off;
    logic                     wr_en;

    assign access   = i_psel && i_apbi.psel && i_apbi.penable;
    assign ready    = access && (wait_cnt == WAIT_W'(P_WAIT));
    assign word_off = i_apbi.paddr[SLV_REGION_BITS-1:2];   // Word offset inside the region
    assign bad_off  = (word_off >= P_NREGS);
    assign wr_en    = ready && i_apbi.pwrite && !bad_off;

    // Counts access cycles until pready
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            wait_cnt <= '0;
        end else if (!access || ready) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + WAIT_W'(1);
        end
    end

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            for (int r = 0; r < P_NREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_en) begin
            for (int r = 0; r < P_NREGS; r++) begin
                if (word_off == OFF_W'(r)) begin
                    for (int b = 0; b < APB_STRB_BITS; b++) begin
                        if (i_apbi.pstrb[b]) begin
                            regs[r][8*b +: 8] <= i_apbi.pwdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // No match past P_NREGS, so a bad offset reads as zero
    always_comb begin
        rd_word = '0;
        for (int r = 0; r < P_NREGS; r++) begin
            if (word_off == OFF_W'(r)) begin
                rd_word = regs[r];
            end
        end
    end

    assign o_apbo = '{
        prdata:  (access && !i_apbi.pwrite) ? rd_word : '0,
        pready:  ready,
        pslverr: ready && bad_off
    };

endmodule

`default_nettype wire

// File: rtl/apb_resp_select.sv
`default_nettype none

module apb_resp_select #(
    parameter int P_NSLV = 4
) (
    input  wire apb_bus_pkg::apb_out_t  i_apbo_arr [P_NSLV],
    input  wire logic [$clog2(P_NSLV+1)-1:0] i_sel_idx,
    output apb_bus_pkg::apb_out_t       o_apbo
);
    import apb_bus_pkg::*;

    localparam int IDX_W = $clog2(P_NSLV + 1);

    // Default slave answers unless a mapped index matches
    always_comb begin
        o_apbo = APB_OUT_UNMAPPED;
        for (int i = 0; i < P_NSLV; i++) begin
            if (i_sel_idx == IDX_W'(i)) begin
                o_apbo = i_apbo_arr[i];
            end
        end
    end

    // Indexes above the default slave name nothing
    always_comb begin
        a_sel_range: assert (i_sel_idx <= IDX_W'(P_NSLV))
            else $error("Slave index %0d past the default slave", i_sel_idx);
    end

endmodule

`default_nettype wire

// File: rtl/apb_bus_top.sv
`default_nettype none

module apb_bus_top #(
    parameter int P_NSLV  = 4,
    parameter int P_NREGS = 16,
    parameter int P_WAIT  = 1
) (
    input  wire logic                   i_clk,
    input  wire logic                   i_nrst,
    input  wire apb_bus_pkg::bus_req_t  i_req,
    input  wire logic                   i_req_valid,
    output logic                        o_req_ready,
    output apb_bus_pkg::bus_resp_t      o_resp,
    output logic                        o_resp_valid,
    input  wire logic                   i_resp_ready
);
    import apb_bus_pkg::*;

    localparam int IDX_W = $clog2(P_NSLV + 1);

    bus_req_t         q_req;        // Queue head
    logic             q_valid;
    logic             q_ready;
    apb_in_t          apbi;         // Shared by all slaves
    logic [P_NSLV-1:0] psel;
    logic [IDX_W-1:0] sel_idx;
    apb_out_t         apbo_arr [P_NSLV];
    apb_out_t         apbo_sel;

    bus_req_queue u_queue (
        .i_clk       (i_clk),
        .i_nrst      (i_nrst),
        .i_req       (i_req),
        .i_req_valid (i_req_valid),
        .o_req_ready (o_req_ready),
        .o_req       (q_req),
        .o_req_valid (q_valid),
        .i_req_ready (q_ready)
    );

    apb_bridge #(.P_NSLV(P_NSLV)) u_bridge (
        .i_clk        (i_clk),
        .i_nrst       (i_nrst),
        .i_req        (q_req),
        .i_req_valid  (q_valid),
        .o_req_ready  (q_ready),
        .o_apbi       (apbi),
        .o_psel       (psel),
        .o_sel_idx    (sel_idx),
        .i_apbo       (apbo_sel),
        .o_resp       (o_resp),
        .o_resp_valid (o_resp_valid),
        .i_resp_ready (i_resp_ready)
    );

    for (genvar g = 0; g < P_NSLV; g++) begin : g_slv
        apb_reg_slave #(.P_NREGS(P_NREGS), .P_WAIT(P_WAIT)) u_slave (
            .i_clk  (i_clk),
            .i_nrst (i_nrst),
            .i_apbi (apbi),
            .i_psel (psel[g]),
            .o_apbo (apbo_arr[g])
        );
    end

    apb_resp_select #(.P_NSLV(P_NSLV)) u_select (
        .i_apbo_arr (apbo_arr),
        .i_sel_idx  (sel_idx),
        .o_apbo     (apbo_sel)
    );

endmodule

`default_nettype wire

// File: verif/tb_clkgen.sv
`default_nettype none

module tb_clkgen #(
    parameter int P_HALF_PERIOD = 2,    // Full period of 4 time units
    parameter int P_RST_CYCLES  = 16
) (
    output logic o_clk,
    output logic o_nrst
);

    initial begin
        o_clk = 1'b0;
        forever #(P_HALF_PERIOD) o_clk = ~o_clk;
    end

    // Release reset just after an edge
    initial begin
        o_nrst = 1'b0;
        repeat (P_RST_CYCLES) @(posedge o_clk);
        #1 o_nrst = 1'b1;
    end

endmodule

`default_nettype wire

// File: verif/tb_apb_bus_top.sv
`default_nettype none

module tb_apb_bus_top;
    import apb_bus_pkg::*;

    localparam int NSLV     = 4;
    localparam int NREGS    = 16;
    localparam int NWAIT    = 1;
    localparam int N_RAND4  = 40;                   // Write and read pairs
    localparam int N_WIDE   = 20;
    localparam int N_ERR    = 6;
    localparam int N_BP     = 80;
    localparam int N_REQ    = NSLV * NREGS + 2 * N_RAND4 + 2 * N_WIDE + N_ERR
                              + NSLV * NREGS / 2 + N_BP;
    localparam int TIMEOUT_CYCLES = 200 * N_REQ + 100;

    logic      clk;
    logic      nrst;
    bus_req_t  req;
    logic      req_valid;
    logic      req_ready;
    bus_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;
    logic      bp_on;
    integer    seed;
    integer    ready_seed;
    int        cycle_cnt;
    int        resp_count;
    bus_resp_t exp_head;
    bus_resp_t exp_q [$];                           // Expected responses in request order
    logic [APB_DATA_BITS-1:0] shadow [NSLV][NREGS]; // Reference copy of every slave register

    tb_clkgen u_clkgen (.o_clk(clk), .o_nrst(nrst));

    apb_bus_top #(.P_NSLV(NSLV), .P_NREGS(NREGS), .P_WAIT(NWAIT)) i_dut (
        .i_clk        (clk),
        .i_nrst       (nrst),
        .i_req        (req),
        .i_req_valid  (req_valid),
        .o_req_ready  (req_ready),
        .o_resp       (resp),
        .o_resp_valid (resp_valid),
        .i_resp_ready (resp_ready)
    );

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic compare_resp(input bus_resp_t got, input bus_resp_t exp);
        if (got.rdata !== exp.rdata) begin
            stop_with_failure(
                $sformatf("FAILED o_resp.rdata got 0x%016h expected 0x%016h (resp %0d)",
                          got.rdata, exp.rdata, resp_count));
        end else if (got.err !== exp.err) begin
            stop_with_failure($sformatf("FAILED o_resp.err got 0x%0h expected 0x%0h (resp %0d)",
                                        got.err, exp.err, resp_count));
        end
    endtask

    task automatic compare_level(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_failure($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic bus_req_t make_req(input int unsigned slv, input int unsigned word,
                                          input int unsigned size, input logic write,
                                          input logic last);
        bus_req_t r;
        r.addr  = 32'((slv << SLV_REGION_BITS) | (word << 2));
        r.size  = 8'(size);
        r.write = write;
        r.wdata = {$random(seed), $random(seed)};
        r.wstrb = 8'($random(seed));
        r.last  = last;
        return r;
    endfunction

    // Reference model that also applies writes to the shadow registers
    function automatic bus_resp_t predict_resp(input bus_req_t r);
        bus_resp_t   exp;
        logic [31:0] a;
        int unsigned lane;
        int unsigned region;
        int unsigned word;
        exp.rdata = '0;
        exp.err   = 1'b0;
        if (!r.last) begin
            exp.rdata = '1;                         // Burst refused
            exp.err   = 1'b1;
            return exp;
        end
        a = {r.addr[31:2], 2'b00};
        for (int beat = 0; beat < ((r.size > 8'd4) ? 2 : 1); beat++) begin
            lane   = a[2];
            region = a[31:SLV_REGION_BITS];
            word   = a[SLV_REGION_BITS-1:2];
            if (region >= NSLV) begin
                exp.rdata[32*lane +: 32] = '1;      // Default slave
                exp.err = 1'b1;
            end else if (word >= NREGS) begin
                exp.err = 1'b1;
            end else if (r.write) begin
                for (int b = 0; b < 4; b++) begin
                    if (r.wstrb[4*lane + b]) begin
                        shadow[region][word][8*b +: 8] = r.wdata[32*lane + 8*b +: 8];
                    end
                end
            end else begin
                exp.rdata[32*lane +: 32] = shadow[region][word];
            end
            a = a + 32'd4;
        end
        return exp;
    endfunction

    task automatic send_req(input bus_req_t r);
        logic accepted;
        req       = r;
        req_valid = 1'b1;
        accepted  = 1'b0;
        while (!accepted) begin
            accepted = req_ready;                   // Stable in mid cycle
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
        exp_q.push_back(predict_resp(r));
    endtask

    // Response ready goes random only in the back-pressure phase
    always @(posedge clk) begin : drive_resp_ready
        logic bp_now;
        bp_now = bp_on;                             // Taken at the edge, before stimulus moves
        #1;
        if (bp_now) begin
            resp_ready = (($random(ready_seed) & 3) == 0);
        end else begin
            resp_ready = 1'b1;
        end
    end

    // Monitor samples on the falling edge before the handshake edge
    always @(negedge clk) begin
        if (nrst && !req_ready && exp_q.size() < 2) begin
            stop_with_failure("o_req_ready dropped with fewer than two requests outstanding");
        end else if (nrst && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("A response arrived with no request outstanding");
            end else begin
                exp_head = exp_q.pop_front();
                compare_resp(resp, exp_head);
                resp_count++;
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > TIMEOUT_CYCLES) begin
            stop_with_failure("The run timed out before all responses came back");
        end
    end

    initial begin
        int unsigned slv;
        int unsigned word;
        int unsigned wide;
        int          drain;
        bus_req_t    r;
        seed       = 32'haf2a_99f8;
        ready_seed = 32'haf2a_99f8;
        req        = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        bp_on      = 1'b0;
        cycle_cnt  = 0;
        resp_count = 0;
        for (int s = 0; s < NSLV; s++) begin
            for (int w = 0; w < NREGS; w++) begin
                shadow[s][w] = '0;
            end
        end
        wait (nrst === 1'b1);
        @(posedge clk);
        #1;
        compare_level("o_req_ready", req_ready, 1'b1);
        compare_level("o_resp_valid", resp_valid, 1'b0);
        for (int s = 0; s < NSLV; s++) begin       // Every register reads zero
            for (int w = 0; w < NREGS; w++) begin
                send_req(make_req(s, w, 4, 1'b0, 1'b1));
            end
        end
        for (int n = 0; n < N_RAND4; n++) begin    // Both lanes through word parity
            slv  = rand_below(NSLV);
            word = rand_below(NREGS);
            send_req(make_req(slv, word, 4, 1'b1, 1'b1));
            send_req(make_req(slv, word, 4, 1'b0, 1'b1));
        end
        for (int n = 0; n < N_WIDE; n++) begin
            slv  = rand_below(NSLV);
            word = 2 * rand_below(NREGS / 2);
            send_req(make_req(slv, word, 8, 1'b1, 1'b1));
            send_req(make_req(slv, word, 8, 1'b0, 1'b1));
        end
        send_req(make_req(NSLV, 0, 8, 1'b0, 1'b1));         // Unmapped read
        send_req(make_req(NSLV + 3, 1, 4, 1'b1, 1'b1));     // Unmapped write in the upper lane
        send_req(make_req(1, NREGS, 4, 1'b0, 1'b1));        // Offset past the bank
        send_req(make_req(2, NREGS, 8, 1'b1, 1'b1));
        send_req(make_req(0, 2, 8, 1'b1, 1'b0));            // Bursts
        send_req(make_req(3, 5, 4, 1'b0, 1'b0));
        for (int s = 0; s < NSLV; s++) begin       // Nothing changed by the errors
            for (int w = 0; w < NREGS; w += 2) begin
                send_req(make_req(s, w, 8, 1'b0, 1'b1));
            end
        end
        bp_on = 1'b1;
        for (int n = 0; n < N_BP; n++) begin
            slv  = rand_below(NSLV + 1);            // Default slave now and then
            wide = rand_below(2);
            word = (wide != 0) ? 2 * rand_below(NREGS / 2) : rand_below(NREGS);
            r    = make_req(slv, word, (wide != 0) ? 8 : 4, rand_below(2) != 0, 1'b1);
            send_req(r);
        end
        bp_on = 1'b0;
        drain = 0;
        while (exp_q.size() != 0 && drain < 1000) begin
            @(posedge clk);
            drain++;
        end
        if (exp_q.size() != 0) begin
            stop_with_failure("Responses were still missing after the last request");
        end else begin
            $display("Regression passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: apb_bus.f
rtl/apb_bus_pkg.sv
rtl/bus_req_queue.sv
rtl/apb_bridge.sv
rtl/apb_reg_slave.sv
rtl/apb_resp_select.sv
rtl/apb_bus_top.sv
verif/tb_clkgen.sv
verif/tb_apb_bus_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_apb_bus_top
FILELIST  ?= apb_bus.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
